// File: logic/rv_ctrl_pkg.sv
`include "rv_decode_settings.svh"

package rv_ctrl_pkg;

    // ALU operation, ADD is zero so an illegal decode reads as all zeros
    typedef enum logic [`ALU_OPT_WIDTH-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        // Operand B straight through, used by LUI
        PASS_B = 4'd10
    } alu_opt_t;

    // Operand sources
    // Bit 1 high takes pc as operand A, low takes rs1
    // Bit 0 high takes imm as operand B, low takes rs2
    typedef enum logic [`SRC_SEL_WIDTH-1:0] {
        SRC_RS1_RS2 = 2'b00,
        SRC_RS1_IMM = 2'b01,
        SRC_PC_RS2  = 2'b10,
        SRC_PC_IMM  = 2'b11
    } src_sel_t;

    // Memory access kind, NONE for every non-memory instruction
    typedef enum logic [`LSU_OPT_WIDTH-1:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } lsu_opt_t;

endpackage

// File: logic/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Instruction word width, fixed by RV32I
`define INST_WIDTH      32

// Immediate and data path width
`define DATA_WIDTH      32

// Register index width, 32 architectural registers
`define REG_WIDTH       5

// ALU operation code width
`define ALU_OPT_WIDTH   4

// Operand source select width, one bit per ALU operand
`define SRC_SEL_WIDTH   2

// Load/store operation code width
`define LSU_OPT_WIDTH   4

`endif

// File: logic/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`INST_WIDTH-1:0]  in_inst,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`REG_WIDTH-1:0]   out_rs1,
    output logic [`REG_WIDTH-1:0]   out_rs2,
    output logic [`REG_WIDTH-1:0]   out_rd,
    output logic                    out_rd_wen,
    output logic [`DATA_WIDTH-1:0]  out_imm,
    output logic                    out_branch,
    output logic                    out_jal,
    output logic                    out_jalr,
    output logic [2:0]              out_funct3,
    output rv_ctrl_pkg::alu_opt_t   out_alu_opt,
    output rv_ctrl_pkg::src_sel_t   out_src_sel,
    output rv_ctrl_pkg::lsu_opt_t   out_lsu_opt,
    output logic                    out_illegal
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Stage 1, raw instruction word
    rv_inst_t s1_inst;
    logic     s1_valid;
    // Stage 2 valid, payload lives in the out_ registers
    logic     s2_valid;
    logic     s2_advance;

    // Combinational decode of the stage 1 word
    logic [`REG_WIDTH-1:0]  id_rs1;
    logic [`REG_WIDTH-1:0]  id_rs2;
    logic [`REG_WIDTH-1:0]  id_rd;
    logic                   id_rd_wen;
    logic [`DATA_WIDTH-1:0] id_imm;
    logic                   id_branch;
    logic                   id_jal;
    logic                   id_jalr;
    logic [2:0]             id_funct3;
    alu_opt_t               id_alu_opt;
    src_sel_t               id_src_sel;
    lsu_opt_t               id_lsu_opt;
    logic                   id_illegal;

    // A stage moves when it is empty or the next one takes its data
    assign s2_advance = !s2_valid || out_ready;
    assign in_ready   = !s1_valid || s2_advance;
    assign out_valid  = s2_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    // Word only captured on a real transfer
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            s1_inst <= in_inst;
        end
    end

    rv_idu i_rv_idu (
        .inst    (s1_inst),
        .branch  (id_branch),
        .jal     (id_jal),
        .jalr    (id_jalr),
        .rd      (id_rd),
        .rd_wen  (id_rd_wen),
        .rs1     (id_rs1),
        .rs2     (id_rs2),
        .imm     (id_imm),
        .alu_opt (id_alu_opt),
        .src_sel (id_src_sel),
        .lsu_opt (id_lsu_opt),
        .funct3  (id_funct3),
        .illegal (id_illegal)
    );

    // Stage 2, held while out_valid is high and out_ready low
    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid    <= 1'b0;
            out_rs1     <= '0;
            out_rs2     <= '0;
            out_rd      <= '0;
            out_rd_wen  <= 1'b0;
            out_imm     <= '0;
            out_branch  <= 1'b0;
            out_jal     <= 1'b0;
            out_jalr    <= 1'b0;
            out_funct3  <= '0;
            out_alu_opt <= ADD;
            out_src_sel <= SRC_RS1_RS2;
            out_lsu_opt <= NONE;
            out_illegal <= 1'b0;
        end else if (s2_advance) begin
            s2_valid <= s1_valid;
            // Bubbles leave the last payload in place
            if (s1_valid) begin
                out_rs1     <= id_rs1;
                out_rs2     <= id_rs2;
                out_rd      <= id_rd;
                out_rd_wen  <= id_rd_wen;
                out_imm     <= id_imm;
                out_branch  <= id_branch;
                out_jal     <= id_jal;
                out_jalr    <= id_jalr;
                out_funct3  <= id_funct3;
                out_alu_opt <= id_alu_opt;
                out_src_sel <= id_src_sel;
                out_lsu_opt <= id_lsu_opt;
                out_illegal <= id_illegal;
            end
        end
    end

endmodule

// File: logic/rv_id_imm.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_id_imm (
    input  rv_isa_pkg::rv_inst_t    inst,
    output logic [`DATA_WIDTH-1:0]  imm
);

    import rv_isa_pkg::*;

    logic [`DATA_WIDTH-1:0] imm_i;
    logic [`DATA_WIDTH-1:0] imm_s;
    logic [`DATA_WIDTH-1:0] imm_b;
    logic [`DATA_WIDTH-1:0] imm_u;
    logic [`DATA_WIDTH-1:0] imm_j;

    // All formats keep the sign in bit 31 of the word
    assign imm_i = {{(`DATA_WIDTH-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};

    assign imm_s = {{(`DATA_WIDTH-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};

    // Branch offset in halfwords
    assign imm_b = {{(`DATA_WIDTH-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};

    // Upper 20 bits, low 12 cleared
    assign imm_u = {inst.u.imm_31_12, 12'b0};

    assign imm_j = {{(`DATA_WIDTH-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    // Format chosen by opcode
    always_comb begin
        case (inst.r.opcode)
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: imm = imm_i;
            OPC_STORE:  imm = imm_s;
            OPC_BRANCH: imm = imm_b;
            OPC_LUI,
            OPC_AUIPC:  imm = imm_u;
            OPC_JAL:    imm = imm_j;
            // OP, FENCE, SYS and unknown opcodes carry no immediate here
            default:    imm = '0;
        endcase
    end

endmodule

// File: logic/rv_id_opt.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_id_opt (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    output rv_ctrl_pkg::alu_opt_t   alu_opt,
    output rv_ctrl_pkg::src_sel_t   src_sel,
    output rv_ctrl_pkg::lsu_opt_t   lsu_opt
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Shared funct3 table of OP and OP_IMM
    // alt selects SUB over ADD and SRA over SRL
    function automatic alu_opt_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_opt_t op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    logic op_alt;
    logic op_imm_alt;

    // Register form reads funct7[5] for both SUB and SRA
    assign op_alt = funct7[5];

    // Immediate form has no SUBI, bit 5 only matters for the right shift
    assign op_imm_alt = funct7[5] && (funct3 == 3'b101);

    // ALU operation and operand sources
    always_comb begin
        alu_opt = ADD;
        src_sel = SRC_RS1_RS2;
        case (opcode)
            OPC_LUI: begin
                alu_opt = PASS_B;
                src_sel = SRC_RS1_IMM;
            end
            // pc relative address or link target
            OPC_AUIPC,
            OPC_JAL: begin
                alu_opt = ADD;
                src_sel = SRC_PC_IMM;
            end
            // Base plus offset
            OPC_JALR,
            OPC_LOAD,
            OPC_STORE: begin
                alu_opt = ADD;
                src_sel = SRC_RS1_IMM;
            end
            // Compare by subtraction
            OPC_BRANCH: begin
                alu_opt = SUB;
                src_sel = SRC_RS1_RS2;
            end
            OPC_OP_IMM: begin
                alu_opt = alu_from_funct3(funct3, op_imm_alt);
                src_sel = SRC_RS1_IMM;
            end
            OPC_OP: begin
                alu_opt = alu_from_funct3(funct3, op_alt);
                src_sel = SRC_RS1_RS2;
            end
            // FENCE, SYS and unknown opcodes keep the zero defaults
            default: begin
                alu_opt = ADD;
                src_sel = SRC_RS1_RS2;
            end
        endcase
    end

    // Memory access width and signedness from funct3
    always_comb begin
        lsu_opt = NONE;
        if (opcode == OPC_LOAD) begin
            case (funct3)
                3'b000:  lsu_opt = LB;
                3'b001:  lsu_opt = LH;
                3'b010:  lsu_opt = LW;
                3'b100:  lsu_opt = LBU;
                3'b101:  lsu_opt = LHU;
                default: lsu_opt = NONE;
            endcase
        end else if (opcode == OPC_STORE) begin
            case (funct3)
                3'b000:  lsu_opt = SB;
                3'b001:  lsu_opt = SH;
                3'b010:  lsu_opt = SW;
                default: lsu_opt = NONE;
            endcase
        end
    end

endmodule

// File: logic/rv_idu.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_idu (
    input  rv_isa_pkg::rv_inst_t    inst,
    output logic                    branch,
    output logic                    jal,
    output logic                    jalr,
    output logic [`REG_WIDTH-1:0]   rd,
    output logic                    rd_wen,
    output logic [`REG_WIDTH-1:0]   rs1,
    output logic [`REG_WIDTH-1:0]   rs2,
    output logic [`DATA_WIDTH-1:0]  imm,
    output rv_ctrl_pkg::alu_opt_t   alu_opt,
    output rv_ctrl_pkg::src_sel_t   src_sel,
    output rv_ctrl_pkg::lsu_opt_t   lsu_opt,
    output logic [2:0]              funct3,
    output logic                    illegal
);

    import rv_isa_pkg::*;

    logic [6:0] opcode;

    assign opcode = inst.r.opcode;

    // Control transfer flags
    assign branch = (opcode == OPC_BRANCH);
    assign jal    = (opcode == OPC_JAL);
    assign jalr   = (opcode == OPC_JALR);

    // Register usage per opcode, unused sources read x0
    always_comb begin
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        rd_wen  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL: begin
                rd     = inst.r.rd;
                rd_wen = 1'b1;
            end
            // One source and a destination
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM,
            OPC_SYS: begin
                rs1    = inst.r.rs1;
                rd     = inst.r.rd;
                rd_wen = 1'b1;
            end
            // Two sources, no write back
            OPC_BRANCH,
            OPC_STORE: begin
                rs1 = inst.r.rs1;
                rs2 = inst.r.rs2;
            end
            OPC_OP: begin
                rs1    = inst.r.rs1;
                rs2    = inst.r.rs2;
                rd     = inst.r.rd;
                rd_wen = 1'b1;
            end
            // Ordering hint only, touches no register
            OPC_FENCE: begin
                rd_wen = 1'b0;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // funct3 is the only raw field that needs masking on an illegal word
    // imm and the op codes already fall back to their zero encodings
    assign funct3 = illegal ? 3'b000 : inst.r.funct3;

    rv_id_imm i_rv_id_imm (
        .inst (inst),
        .imm  (imm)
    );

    rv_id_opt i_rv_id_opt (
        .opcode  (opcode),
        .funct3  (inst.r.funct3),
        .funct7  (inst.r.funct7),
        .alu_opt (alu_opt),
        .src_sel (src_sel),
        .lsu_opt (lsu_opt)
    );

endmodule

// File: logic/rv_isa_pkg.sv
`include "rv_decode_settings.svh"

package rv_isa_pkg;

    // Base opcodes of RV32I, bits [6:0] of every instruction
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYS    = 7'b1110011;

    // Register to register format
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_WIDTH-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    // Immediate format, also loads and JALR
    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_WIDTH-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // Store format, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    // Branch format, bit 0 of the offset is implied zero
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    // Upper immediate format
    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`REG_WIDTH-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // Jump format, scrambled 20-bit offset
    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [`REG_WIDTH-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word, seen through any of the six formats
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_t;

endpackage

// File: project.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_id_imm.sv
logic/rv_id_opt.sv
logic/rv_idu.sv
logic/rv_decode_stage.sv
test/rv_decode_props.sv
test/rv_decode_checker.sv
test/tb_rv_decode.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_rv_decode -f project.f -o sim_rv_decode > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_rv_decode > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: test/rv_decode_checker.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_checker #(
    parameter int N_ENTRIES = 1,
    parameter int N_TESTS   = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic                   in_ready,
    input  logic                   strict_timing,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  logic [`REG_WIDTH-1:0]  out_rs1,
    input  logic [`REG_WIDTH-1:0]  out_rs2,
    input  logic [`REG_WIDTH-1:0]  out_rd,
    input  logic                   out_rd_wen,
    input  logic [`DATA_WIDTH-1:0] out_imm,
    input  logic                   out_branch,
    input  logic                   out_jal,
    input  logic                   out_jalr,
    input  logic [2:0]             out_funct3,
    input  rv_ctrl_pkg::alu_opt_t  out_alu_opt,
    input  rv_ctrl_pkg::src_sel_t  out_src_sel,
    input  rv_ctrl_pkg::lsu_opt_t  out_lsu_opt,
    input  logic                   out_illegal,
    input  logic [31:0]            inst_tab [N_ENTRIES],
    input  logic [64:0]            exp_tab [N_ENTRIES],
    output int                     pass_count,
    output int                     fail_count,
    output int                     err_count,
    output int                     done_count
);

    import rv_isa_pkg::*;

    int   cyc;
    int   test_errs;
    int   accept_q[$];
    logic strict_q[$];

    function automatic string opc_name(input logic [6:0] opc);
        case (opc)
            OPC_LUI:    return "lui";
            OPC_AUIPC:  return "auipc";
            OPC_JAL:    return "jal";
            OPC_JALR:   return "jalr";
            OPC_BRANCH: return "branch";
            OPC_LOAD:   return "load";
            OPC_STORE:  return "store";
            OPC_OP_IMM: return "op_imm";
            OPC_OP:     return "op";
            OPC_FENCE:  return "fence";
            OPC_SYS:    return "system";
            default:    return "unknown";
        endcase
    endfunction

    task automatic cmp(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: test %0d field %s got %h expected %h",
                     $time, done_count, name, got, exp);
            test_errs++;
        end
    endtask

    always @(posedge clk) begin
        logic [64:0] e;
        int          idx;
        int          lat;
        logic        exp_ready;
        if (reset) begin
            cyc = 0;
            accept_q.delete();
            strict_q.delete();
        end else begin
            cyc++;
            // Input open while fewer than two words are in flight or the output moves
            exp_ready = (accept_q.size() < 2) || out_ready;
            if (in_ready !== exp_ready) begin
                $display("error at %0t ns: in_ready %b expected %b",
                         $time, in_ready, exp_ready);
                err_count++;
            end
            // Acceptance cycle kept for the latency check
            if (in_valid && in_ready) begin
                accept_q.push_back(cyc);
                strict_q.push_back(strict_timing);
            end
            if (out_valid && out_ready && done_count >= N_TESTS) begin
                $display("error at %0t ns: output beyond the last test", $time);
                err_count++;
            end else if (out_valid && out_ready) begin
                idx       = done_count % N_ENTRIES;
                e         = exp_tab[idx];
                test_errs = 0;
                cmp("rs1", 32'(out_rs1), 32'(e[64:60]));
                cmp("rs2", 32'(out_rs2), 32'(e[59:55]));
                cmp("rd", 32'(out_rd), 32'(e[54:50]));
                cmp("rd_wen", 32'(out_rd_wen), 32'(e[49]));
                cmp("imm", out_imm, e[48:17]);
                cmp("branch", 32'(out_branch), 32'(e[16]));
                cmp("jal", 32'(out_jal), 32'(e[15]));
                cmp("jalr", 32'(out_jalr), 32'(e[14]));
                cmp("funct3", 32'(out_funct3), 32'(e[13:11]));
                cmp("alu_opt", 32'(out_alu_opt), 32'(e[10:7]));
                cmp("src_sel", 32'(out_src_sel), 32'(e[6:5]));
                cmp("lsu_opt", 32'(out_lsu_opt), 32'(e[4:1]));
                cmp("illegal", 32'(out_illegal), 32'(e[0]));
                if (accept_q.size() == 0) begin
                    $display("output arrived with no accepted input behind it");
                    test_errs++;
                end else begin
                    lat = cyc - accept_q.pop_front();
                    if (strict_q.pop_front() && lat != 2) begin
                        $display("error at %0t ns: test %0d latency %0d cycles expected 2",
                                 $time, done_count, lat);
                        test_errs++;
                    end
                end
                if (test_errs == 0) begin
                    pass_count++;
                    $display("test %0d %s ok", done_count, opc_name(inst_tab[idx][6:0]));
                end else begin
                    fail_count++;
                    err_count += test_errs;
                    $display("test %0d %s failed with %0d errors",
                             done_count, opc_name(inst_tab[idx][6:0]), test_errs);
                end
                done_count++;
            end
        end
    end

endmodule

// File: test/rv_decode_props.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [`REG_WIDTH-1:0]    out_rs1,
    input logic [`REG_WIDTH-1:0]    out_rs2,
    input logic [`REG_WIDTH-1:0]    out_rd,
    input logic                     out_rd_wen,
    input logic [`DATA_WIDTH-1:0]   out_imm,
    input logic                     out_branch,
    input logic                     out_jal,
    input logic                     out_jalr,
    input logic [2:0]               out_funct3,
    input logic [`ALU_OPT_WIDTH-1:0] out_alu_opt,
    input logic [`SRC_SEL_WIDTH-1:0] out_src_sel,
    input logic [`LSU_OPT_WIDTH-1:0] out_lsu_opt,
    input logic                     out_illegal
);

    logic [64:0] payload;

    assign payload = {out_rs1, out_rs2, out_rd, out_rd_wen, out_imm, out_branch, out_jal,
                      out_jalr, out_funct3, out_alu_opt, out_src_sel, out_lsu_opt, out_illegal};

    a_no_x: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({in_ready, out_valid, payload}))
        else $error("unknown value on a DUT output");

    // Stalled output keeps valid and payload
    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(payload))
        else $error("output changed while stalled");

    a_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high right after reset");

endmodule

bind rv_decode_stage rv_decode_props i_rv_decode_props (.*);

// File: test/tb_rv_decode.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_rv_decode;

    // Table applied twice, strict timing first, then random gaps and stalls
    localparam int N_ENTRIES  = 39;
    localparam int N_TESTS    = 2 * N_ENTRIES;
    localparam int MAX_CYCLES = 16 + 4 * N_TESTS + 100;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    logic [`INST_WIDTH-1:0] in_inst;
    logic                   out_valid;
    logic                   out_ready;
    logic [`REG_WIDTH-1:0]  out_rs1;
    logic [`REG_WIDTH-1:0]  out_rs2;
    logic [`REG_WIDTH-1:0]  out_rd;
    logic                   out_rd_wen;
    logic [`DATA_WIDTH-1:0] out_imm;
    logic                   out_branch;
    logic                   out_jal;
    logic                   out_jalr;
    logic [2:0]             out_funct3;
    rv_ctrl_pkg::alu_opt_t  out_alu_opt;
    rv_ctrl_pkg::src_sel_t  out_src_sel;
    rv_ctrl_pkg::lsu_opt_t  out_lsu_opt;
    logic                   out_illegal;

    logic [31:0] inst_tab [N_ENTRIES];
    logic [64:0] exp_tab [N_ENTRIES];
    int          n_filled;
    logic        strict_timing;
    logic        took;
    logic [15:0] lfsr;
    int          cycles = 0;
    int          pass_count;
    int          fail_count;
    int          err_count;
    int          done_count;

    rv_decode_stage i_rv_decode_stage (.*);

    rv_decode_checker #(
        .N_ENTRIES (N_ENTRIES),
        .N_TESTS   (N_TESTS)
    ) i_rv_decode_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Input transfer seen at the last edge
    always @(posedge clk) begin
        took <= in_valid && in_ready;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    task automatic add_entry(input int inst, input int rs1, input int rs2, input int rd,
                             input int wen, input int imm, input int br, input int jal,
                             input int jalr, input int f3, input int alu, input int src,
                             input int lsu, input int ill);
        inst_tab[n_filled] = 32'(inst);
        exp_tab[n_filled]  = {5'(rs1), 5'(rs2), 5'(rd), 1'(wen), 32'(imm), 1'(br), 1'(jal),
                              1'(jalr), 3'(f3), 4'(alu), 2'(src), 4'(lsu), 1'(ill)};
        n_filled++;
    endtask

    // inst, rs1, rs2, rd, wen, imm, branch, jal, jalr, funct3, alu, src, lsu, illegal
    // alu ADD 0 SUB 1 SLL 2 SLT 3 SLTU 4 XOR 5 SRL 6 SRA 7 OR 8 AND 9 PASS_B 10
    // lsu NONE 0 LB 1 LH 2 LW 3 LBU 4 LHU 5 SB 6 SH 7 SW 8
    task automatic fill_table();
        add_entry(32'h123452B7, 0, 0, 5, 1, 32'h12345000, 0, 0, 0, 5, 10, 1, 0, 0);
        add_entry(32'hFFFFF0B7, 0, 0, 1, 1, 32'hFFFFF000, 0, 0, 0, 7, 10, 1, 0, 0);
        add_entry(32'h80000197, 0, 0, 3, 1, 32'h80000000, 0, 0, 0, 0, 0, 3, 0, 0);
        add_entry(32'h008000EF, 0, 0, 1, 1, 32'h00000008, 0, 1, 0, 0, 0, 3, 0, 0);
        add_entry(32'hFFDFF06F, 0, 0, 0, 1, 32'hFFFFFFFC, 0, 1, 0, 7, 0, 3, 0, 0);
        add_entry(32'h004100E7, 2, 0, 1, 1, 32'h00000004, 0, 0, 1, 0, 0, 1, 0, 0);
        add_entry(32'h00208863, 1, 2, 0, 0, 32'h00000010, 1, 0, 0, 0, 1, 0, 0, 0);
        add_entry(32'hFE419CE3, 3, 4, 0, 0, 32'hFFFFFFF8, 1, 0, 0, 1, 1, 0, 0, 0);
        // Loads
        add_entry(32'h00010083, 2, 0, 1, 1, 32'h00000000, 0, 0, 0, 0, 0, 1, 1, 0);
        add_entry(32'hFFE21183, 4, 0, 3, 1, 32'hFFFFFFFE, 0, 0, 0, 1, 0, 1, 2, 0);
        add_entry(32'h00832283, 6, 0, 5, 1, 32'h00000008, 0, 0, 0, 2, 0, 1, 3, 0);
        add_entry(32'h00144383, 8, 0, 7, 1, 32'h00000001, 0, 0, 0, 4, 0, 1, 4, 0);
        add_entry(32'h00255483, 10, 0, 9, 1, 32'h00000002, 0, 0, 0, 5, 0, 1, 5, 0);
        // Stores
        add_entry(32'h00208223, 1, 2, 0, 0, 32'h00000004, 0, 0, 0, 0, 0, 1, 6, 0);
        add_entry(32'hFE329E23, 5, 3, 0, 0, 32'hFFFFFFFC, 0, 0, 0, 1, 0, 1, 7, 0);
        add_entry(32'h02432023, 6, 4, 0, 0, 32'h00000020, 0, 0, 0, 2, 0, 1, 8, 0);
        // Immediate ALU forms
        add_entry(32'hFFF10093, 2, 0, 1, 1, 32'hFFFFFFFF, 0, 0, 0, 0, 0, 1, 0, 0);
        add_entry(32'h00522193, 4, 0, 3, 1, 32'h00000005, 0, 0, 0, 2, 3, 1, 0, 0);
        add_entry(32'h00733293, 6, 0, 5, 1, 32'h00000007, 0, 0, 0, 3, 4, 1, 0, 0);
        add_entry(32'h7FF44393, 8, 0, 7, 1, 32'h000007FF, 0, 0, 0, 4, 5, 1, 0, 0);
        add_entry(32'h10056493, 10, 0, 9, 1, 32'h00000100, 0, 0, 0, 6, 8, 1, 0, 0);
        add_entry(32'h0F067593, 12, 0, 11, 1, 32'h000000F0, 0, 0, 0, 7, 9, 1, 0, 0);
        add_entry(32'h00311093, 2, 0, 1, 1, 32'h00000003, 0, 0, 0, 1, 2, 1, 0, 0);
        add_entry(32'h00425193, 4, 0, 3, 1, 32'h00000004, 0, 0, 0, 5, 6, 1, 0, 0);
        add_entry(32'h40235293, 6, 0, 5, 1, 32'h00000402, 0, 0, 0, 5, 7, 1, 0, 0);
        // Register ALU forms
        add_entry(32'h003100B3, 2, 3, 1, 1, 32'h00000000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry(32'h40628233, 5, 6, 4, 1, 32'h00000000, 0, 0, 0, 0, 1, 0, 0, 0);
        add_entry(32'h009413B3, 8, 9, 7, 1, 32'h00000000, 0, 0, 0, 1, 2, 0, 0, 0);
        add_entry(32'h00C5A533, 11, 12, 10, 1, 32'h00000000, 0, 0, 0, 2, 3, 0, 0, 0);
        add_entry(32'h00F736B3, 14, 15, 13, 1, 32'h00000000, 0, 0, 0, 3, 4, 0, 0, 0);
        add_entry(32'h0128C833, 17, 18, 16, 1, 32'h00000000, 0, 0, 0, 4, 5, 0, 0, 0);
        add_entry(32'h003150B3, 2, 3, 1, 1, 32'h00000000, 0, 0, 0, 5, 6, 0, 0, 0);
        add_entry(32'h403150B3, 2, 3, 1, 1, 32'h00000000, 0, 0, 0, 5, 7, 0, 0, 0);
        add_entry(32'h003160B3, 2, 3, 1, 1, 32'h00000000, 0, 0, 0, 6, 8, 0, 0, 0);
        add_entry(32'h003170B3, 2, 3, 1, 1, 32'h00000000, 0, 0, 0, 7, 9, 0, 0, 0);
        // FENCE, CSRRW, then two unknown opcodes
        add_entry(32'h0FF0000F, 0, 0, 0, 0, 32'h00000000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry(32'h300110F3, 2, 0, 1, 1, 32'h00000000, 0, 0, 0, 1, 0, 0, 0, 0);
        add_entry(32'hFFFFFFFF, 0, 0, 0, 0, 32'h00000000, 0, 0, 0, 0, 0, 0, 0, 1);
        add_entry(32'hABCDE05B, 0, 0, 0, 0, 32'h00000000, 0, 0, 0, 0, 0, 0, 0, 1);
    endtask

    task automatic step_random();
        @(posedge clk);
        #1;
        out_ready = lfsr_bit();
    endtask

    // Offer one word and hold it until the DUT takes it
    task automatic send(input logic [31:0] inst, input logic random_mode);
        if (random_mode && lfsr_bit()) begin
            in_valid = 1'b0;
            step_random();
        end
        in_valid = 1'b1;
        in_inst  = inst;
        do begin
            if (random_mode) begin
                step_random();
            end else begin
                @(posedge clk);
                #1;
            end
        end while (!took);
    endtask

    initial begin
        int i;
        in_valid      = 1'b0;
        in_inst       = '0;
        out_ready     = 1'b0;
        reset         = 1'b1;
        strict_timing = 1'b1;
        lfsr          = 16'd4;
        n_filled      = 0;
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        reset     = 1'b0;
        out_ready = 1'b1;
        // Back to back, no stalls
        for (i = 0; i < N_ENTRIES; i++) begin
            send(inst_tab[i], 1'b0);
        end
        in_valid = 1'b0;
        while (done_count < N_ENTRIES) begin
            @(posedge clk);
            #1;
        end
        strict_timing = 1'b0;
        for (i = 0; i < N_ENTRIES; i++) begin
            send(inst_tab[i], 1'b1);
        end
        in_valid = 1'b0;
        while (done_count < N_TESTS) begin
            step_random();
        end
        // Room for a duplicate to show up
        repeat (4) step_random();
        $display("tests %0d  passed %0d  failed %0d  errors %0d",
                 done_count, pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0 && done_count == N_TESTS) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
